// ==== sim.f ====
+incdir+tb
design/jpeg_coef_pkg.sv
design/jpeg_huff_pkg.sv
design/ac_category_calc.sv
design/ac_huff_table_lum.sv
design/ac_code_pack.sv
design/ac_encoder_lum.sv
tb/tb_ac_encoder.sv

// ==== tb/tb_ac_ref.svh ====
`ifndef TB_AC_REF_SVH
`define TB_AC_REF_SVH

// size category is the number of bits in the magnitude
function automatic cat_t category_of(input coef_t c);
	int mag;
	int cat;
	mag = (c < 0) ? -int'(c) : int'(c);
	cat = 0;
	while (mag != 0) begin
		cat++;
		mag = mag >> 1;
	end
	return cat_t'(cat);
endfunction

function automatic addl_t addl_of(input coef_t c);
	int v;
	int cat;
	v = int'(c);
	cat = int'(category_of(c));
	if (v >= 0)
		return addl_t'(v);
	else
		return addl_t'(~(-v) & ((1 << cat) - 1));	// ones' complement of the magnitude
endfunction

// code on top, additional bits below it
function automatic logic [EXT_W-1:0] join_code(input logic [15:0] code, input cat_t cat,
	input addl_t addl);
	return (EXT_W'(code) << cat) | EXT_W'(addl);
endfunction

// a few K.5 entries, enough to check whole extended codes
function automatic bit known_code(input run_t r, input cat_t cat, output logic [15:0] code,
	output logic [4:0] len);
	bit hit;
	hit = 1'b1;
	code = '0;
	len = '0;
	if (cat == 0) begin
		if (r == 4'd15) begin
			code = 16'b11111111001;	// ZRL
			len = 5'd11;
		end else begin
			code = 16'b1010;	// EOB, also where other runs fall back
			len = 5'd4;
		end
	end else begin
		case ({r, cat})
			8'h01: begin
				code = 16'b00;
				len = 5'd2;
			end
			8'h02: begin
				code = 16'b01;
				len = 5'd2;
			end
			8'h03: begin
				code = 16'b100;
				len = 5'd3;
			end
			8'h04: begin
				code = 16'b1011;
				len = 5'd4;
			end
			8'h11: begin
				code = 16'b1100;
				len = 5'd4;
			end
			8'h21: begin
				code = 16'b11100;
				len = 5'd5;
			end
			8'h0a: begin
				code = 16'b1111111110000011;
				len = 5'd16;
			end
			default: hit = 1'b0;
		endcase
	end
	return hit;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

`endif

// ==== tb/tb_ac_encoder.sv ====
`timescale 1ns/1ns

module tb_ac_encoder;
	import jpeg_coef_pkg::*;
	import jpeg_huff_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_DIRECTED = 21;	// directed slots, idle ones included
	localparam int NUM_RANDOM = 400;
	localparam int NUM_TESTS = NUM_DIRECTED + NUM_RANDOM;
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_TESTS + 20) * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'hd887_0698;

	typedef struct packed {
		run_t run;
		coef_t coef;
		cat_t cat;
		addl_t addl;
		logic known;
		logic [15:0] code;
		logic [4:0] len;
		int due;	// cycle in which out_valid must show it
	} exp_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	run_t run;
	coef_t coef;
	logic out_valid;
	ac_out_t out;

	exp_t exp_q[$];
	exp_t head;
	ac_out_t last_out = '0;
	logic [31:0] rng = SEED;
	int cycle_cnt = 0;

	`include "tb_ac_ref.svh"

	ac_encoder_lum u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.run(run),
		.coef(coef),
		.out_valid(out_valid),
		.out(out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	task automatic end_in_failure();
		$display("test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic describe_error(input string what);
		$display("ERROR: %s", what);
		end_in_failure();
	endtask

	task automatic show_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end_in_failure();
	endtask

	task automatic apply_coef(input int r, input int c);
		exp_t e;
		logic [15:0] code;
		logic [4:0] len;
		@(posedge clk);
		#2;
		in_valid = 1'b1;
		run = run_t'(r);
		coef = coef_t'(c);
		e.run = run;
		e.coef = coef;
		e.cat = category_of(coef);
		e.addl = addl_of(coef);
		e.known = known_code(run, e.cat, code, len);
		e.code = code;
		e.len = len;
		e.due = cycle_cnt + 1;	// captured at the next edge
		exp_q.push_back(e);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		rng = xorshift32(rng);
		run = rng[3:0];	// junk that must not reach out
		coef = coef_t'(rng[13:4]);
	endtask

	task automatic check_record(input exp_t e, input ac_out_t o);
		logic [EXT_W-1:0] mask;
		logic [EXT_W-1:0] code_part;
		int code_len;
		mask = (EXT_W'(1) << e.cat) - 1;
		assert ((o.ext_code & mask) == EXT_W'(e.addl))
		else show_mismatch("out.ext_code (additional bits)", e.addl, o.ext_code & mask);
		code_len = int'(o.num_bits) - int'(e.cat);
		code_part = o.ext_code >> e.cat;
		assert (code_len >= 2 && code_len <= 16)
		else describe_error($sformatf("bit count %0d gives no valid code length for category %0d",
			o.num_bits, e.cat));
		assert ((code_part >> code_len) == 0)
		else describe_error($sformatf("code for run %0d coef %0d is wider than %0d bits",
			e.run, e.coef, code_len));
		if (e.known) begin
			assert (o.num_bits == e.len + e.cat)
			else show_mismatch("out.num_bits", e.len + e.cat, o.num_bits);
			assert (o.ext_code == join_code(e.code, e.cat, e.addl))
			else show_mismatch("out.ext_code", join_code(e.code, e.cat, e.addl), o.ext_code);
		end
		if (code_len == 16) begin
			// every 16-bit code of K.5 starts with nine ones
			assert (code_part[15:7] == 9'h1ff)
			else show_mismatch("out.ext_code (code prefix)", 9'h1ff, code_part[15:7]);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (out_valid) begin
			assert (exp_q.size() != 0)
			else describe_error("out_valid went high with no input pending");
			head = exp_q.pop_front();
			assert (head.due == cycle_cnt)
			else describe_error($sformatf("output for coef %0d came in cycle %0d, due in %0d",
				head.coef, cycle_cnt, head.due));
			check_record(head, out);
			last_out = out;
		end else begin
			assert (out == last_out)
			else show_mismatch("out (held)", last_out, out);
			if (exp_q.size() != 0)
				assert (exp_q[0].due > cycle_cnt)
				else describe_error("out_valid stayed low when an output was due");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		describe_error("watchdog expired before the test finished");
	end

	initial begin
		int k;
		int mag;
		rst_n = 1'b0;
		in_valid = 1'b0;
		run = '0;
		coef = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		assert (out == '0)
		else show_mismatch("out", '0, out);

		apply_coef(0, 0);	// EOB
		apply_coef(15, 0);	// ZRL
		apply_coef(0, 1);
		apply_coef(0, -1);
		apply_coef(0, 2);
		apply_coef(0, -3);
		apply_coef(0, 5);
		apply_coef(0, -6);
		apply_coef(0, 9);
		apply_coef(0, -15);
		apply_coef(1, 1);
		apply_coef(1, -1);
		idle_cycle();
		apply_coef(2, 1);
		apply_coef(2, -1);
		apply_coef(0, 1023);
		apply_coef(0, -1023);
		apply_coef(0, 512);
		apply_coef(0, -512);
		apply_coef(7, 0);	// size 0 falls back to EOB
		idle_cycle();

		for (int i = 0; i < NUM_RANDOM; i++) begin
			rng = xorshift32(rng);
			if (rng[3:0] == 4'd0) begin
				idle_cycle();
			end else begin
				k = int'(rng[7:4]) % (MAX_CAT + 1);
				mag = int'(rng[31:12]) & ((1 << k) - 1);	// ten bits at most, so within 1023
				apply_coef(int'(rng[11:8]), rng[2] ? -mag : mag);
			end
		end

		repeat (3) idle_cycle();
		@(negedge clk);
		assert (exp_q.size() == 0)
		else describe_error($sformatf("%0d inputs never got an output", exp_q.size()));
		$display("test passed");
		$finish;
	end

endmodule

// ==== design/ac_encoder_lum.sv ====
`timescale 1ns/1ns

module ac_encoder_lum (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input jpeg_coef_pkg::run_t run,
	input jpeg_coef_pkg::coef_t coef,
	output logic out_valid,
	output jpeg_huff_pkg::ac_out_t out
);
	import jpeg_coef_pkg::*;
	import jpeg_huff_pkg::*;

	cat_t category;
	addl_t addl;
	ac_sym_t sym;
	huff_code_t code;

	ac_category_calc u_category (
		.coef(coef),
		.category(category),
		.addl(addl)
	);

	assign sym = '{run: run, cat: category};	// table address

	ac_huff_table_lum u_table (
		.sym(sym),
		.code(code)
	);

	ac_code_pack u_pack (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.category(category),
		.addl(addl),
		.code(code),
		.out_valid(out_valid),
		.out(out)
	);

endmodule

// ==== design/ac_code_pack.sv ====
`timescale 1ns/1ns

module ac_code_pack (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input jpeg_coef_pkg::cat_t category,
	input jpeg_coef_pkg::addl_t addl,
	input jpeg_huff_pkg::huff_code_t code,
	output logic out_valid,
	output jpeg_huff_pkg::ac_out_t out
);
	import jpeg_huff_pkg::*;

	logic [EXT_W-1:0] addl_mask;
	logic [EXT_W-1:0] code_shift;
	ac_out_t pack_nxt;

	// keep only the low category bits of addl
	assign addl_mask = ~({EXT_W{1'b1}} << category);
	assign code_shift = EXT_W'(code.code) << category;

	assign pack_nxt.ext_code = code_shift | (EXT_W'(addl) & addl_mask);
	assign pack_nxt.num_bits = code.length + LEN_W'(category);	// max 16 + 10

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out <= '0;
		end else begin
			out_valid <= in_valid;
			if (in_valid)
				out <= pack_nxt;	// holds between strobes
		end
	end

endmodule

// ==== design/ac_huff_table_lum.sv ====
`timescale 1ns/1ns

module ac_huff_table_lum (
	input jpeg_coef_pkg::ac_sym_t sym,
	output jpeg_huff_pkg::huff_code_t code
);

	always_comb begin
		case (sym)
			8'h00: code = '{16'b1010, 5'd4};	// EOB
			8'h01: code = '{16'b00, 5'd2};
			8'h02: code = '{16'b01, 5'd2};
			8'h03: code = '{16'b100, 5'd3};
			8'h04: code = '{16'b1011, 5'd4};
			8'h05: code = '{16'b11010, 5'd5};
			8'h06: code = '{16'b1111000, 5'd7};
			8'h07: code = '{16'b11111000, 5'd8};
			8'h08: code = '{16'b1111110110, 5'd10};
			8'h09: code = '{16'hff82, 5'd16};
			8'h0a: code = '{16'hff83, 5'd16};
			8'h11: code = '{16'b1100, 5'd4};
			8'h12: code = '{16'b11011, 5'd5};
			8'h13: code = '{16'b1111001, 5'd7};
			8'h14: code = '{16'b111110110, 5'd9};
			8'h15: code = '{16'b11111110110, 5'd11};
			8'h16: code = '{16'hff84, 5'd16};
			8'h17: code = '{16'hff85, 5'd16};
			8'h18: code = '{16'hff86, 5'd16};
			8'h19: code = '{16'hff87, 5'd16};
			8'h1a: code = '{16'hff88, 5'd16};
			8'h21: code = '{16'b11100, 5'd5};
			8'h22: code = '{16'b11111001, 5'd8};
			8'h23: code = '{16'b1111110111, 5'd10};
			8'h24: code = '{16'b111111110100, 5'd12};
			8'h25: code = '{16'hff89, 5'd16};
			8'h26: code = '{16'hff8a, 5'd16};
			8'h27: code = '{16'hff8b, 5'd16};
			8'h28: code = '{16'hff8c, 5'd16};
			8'h29: code = '{16'hff8d, 5'd16};
			8'h2a: code = '{16'hff8e, 5'd16};
			8'h31: code = '{16'b111010, 5'd6};
			8'h32: code = '{16'b111110111, 5'd9};
			8'h33: code = '{16'b111111110101, 5'd12};
			8'h34: code = '{16'hff8f, 5'd16};
			8'h35: code = '{16'hff90, 5'd16};
			8'h36: code = '{16'hff91, 5'd16};
			8'h37: code = '{16'hff92, 5'd16};
			8'h38: code = '{16'hff93, 5'd16};
			8'h39: code = '{16'hff94, 5'd16};
			8'h3a: code = '{16'hff95, 5'd16};
			8'h41: code = '{16'b111011, 5'd6};
			8'h42: code = '{16'b1111111000, 5'd10};
			8'h43: code = '{16'hff96, 5'd16};
			8'h44: code = '{16'hff97, 5'd16};
			8'h45: code = '{16'hff98, 5'd16};
			8'h46: code = '{16'hff99, 5'd16};
			8'h47: code = '{16'hff9a, 5'd16};
			8'h48: code = '{16'hff9b, 5'd16};
			8'h49: code = '{16'hff9c, 5'd16};
			8'h4a: code = '{16'hff9d, 5'd16};
			8'h51: code = '{16'b1111010, 5'd7};
			8'h52: code = '{16'b11111110111, 5'd11};
			8'h53: code = '{16'hff9e, 5'd16};
			8'h54: code = '{16'hff9f, 5'd16};
			8'h55: code = '{16'hffa0, 5'd16};
			8'h56: code = '{16'hffa1, 5'd16};
			8'h57: code = '{16'hffa2, 5'd16};
			8'h58: code = '{16'hffa3, 5'd16};
			8'h59: code = '{16'hffa4, 5'd16};
			8'h5a: code = '{16'hffa5, 5'd16};
			8'h61: code = '{16'b1111011, 5'd7};
			8'h62: code = '{16'b111111110110, 5'd12};
			8'h63: code = '{16'hffa6, 5'd16};
			8'h64: code = '{16'hffa7, 5'd16};
			8'h65: code = '{16'hffa8, 5'd16};
			8'h66: code = '{16'hffa9, 5'd16};
			8'h67: code = '{16'hffaa, 5'd16};
			8'h68: code = '{16'hffab, 5'd16};
			8'h69: code = '{16'hffac, 5'd16};
			8'h6a: code = '{16'hffad, 5'd16};
			8'h71: code = '{16'b11111010, 5'd8};
			8'h72: code = '{16'b111111110111, 5'd12};
			8'h73: code = '{16'hffae, 5'd16};
			8'h74: code = '{16'hffaf, 5'd16};
			8'h75: code = '{16'hffb0, 5'd16};
			8'h76: code = '{16'hffb1, 5'd16};
			8'h77: code = '{16'hffb2, 5'd16};
			8'h78: code = '{16'hffb3, 5'd16};
			8'h79: code = '{16'hffb4, 5'd16};
			8'h7a: code = '{16'hffb5, 5'd16};
			8'h81: code = '{16'b111111000, 5'd9};
			8'h82: code = '{16'b111111111000000, 5'd15};	// only 15-bit code
			8'h83: code = '{16'hffb6, 5'd16};
			8'h84: code = '{16'hffb7, 5'd16};
			8'h85: code = '{16'hffb8, 5'd16};
			8'h86: code = '{16'hffb9, 5'd16};
			8'h87: code = '{16'hffba, 5'd16};
			8'h88: code = '{16'hffbb, 5'd16};
			8'h89: code = '{16'hffbc, 5'd16};
			8'h8a: code = '{16'hffbd, 5'd16};
			8'h91: code = '{16'b111111001, 5'd9};
			8'h92: code = '{16'hffbe, 5'd16};
			8'h93: code = '{16'hffbf, 5'd16};
			8'h94: code = '{16'hffc0, 5'd16};
			8'h95: code = '{16'hffc1, 5'd16};
			8'h96: code = '{16'hffc2, 5'd16};
			8'h97: code = '{16'hffc3, 5'd16};
			8'h98: code = '{16'hffc4, 5'd16};
			8'h99: code = '{16'hffc5, 5'd16};
			8'h9a: code = '{16'hffc6, 5'd16};
			8'ha1: code = '{16'b111111010, 5'd9};
			8'ha2: code = '{16'hffc7, 5'd16};
			8'ha3: code = '{16'hffc8, 5'd16};
			8'ha4: code = '{16'hffc9, 5'd16};
			8'ha5: code = '{16'hffca, 5'd16};
			8'ha6: code = '{16'hffcb, 5'd16};
			8'ha7: code = '{16'hffcc, 5'd16};
			8'ha8: code = '{16'hffcd, 5'd16};
			8'ha9: code = '{16'hffce, 5'd16};
			8'haa: code = '{16'hffcf, 5'd16};
			8'hb1: code = '{16'b1111111001, 5'd10};
			8'hb2: code = '{16'hffd0, 5'd16};
			8'hb3: code = '{16'hffd1, 5'd16};
			8'hb4: code = '{16'hffd2, 5'd16};
			8'hb5: code = '{16'hffd3, 5'd16};
			8'hb6: code = '{16'hffd4, 5'd16};
			8'hb7: code = '{16'hffd5, 5'd16};
			8'hb8: code = '{16'hffd6, 5'd16};
			8'hb9: code = '{16'hffd7, 5'd16};
			8'hba: code = '{16'hffd8, 5'd16};
			8'hc1: code = '{16'b1111111010, 5'd10};
			8'hc2: code = '{16'hffd9, 5'd16};
			8'hc3: code = '{16'hffda, 5'd16};
			8'hc4: code = '{16'hffdb, 5'd16};
			8'hc5: code = '{16'hffdc, 5'd16};
			8'hc6: code = '{16'hffdd, 5'd16};
			8'hc7: code = '{16'hffde, 5'd16};
			8'hc8: code = '{16'hffdf, 5'd16};
			8'hc9: code = '{16'hffe0, 5'd16};
			8'hca: code = '{16'hffe1, 5'd16};
			8'hd1: code = '{16'b11111111000, 5'd11};
			8'hd2: code = '{16'hffe2, 5'd16};
			8'hd3: code = '{16'hffe3, 5'd16};
			8'hd4: code = '{16'hffe4, 5'd16};
			8'hd5: code = '{16'hffe5, 5'd16};
			8'hd6: code = '{16'hffe6, 5'd16};
			8'hd7: code = '{16'hffe7, 5'd16};
			8'hd8: code = '{16'hffe8, 5'd16};
			8'hd9: code = '{16'hffe9, 5'd16};
			8'hda: code = '{16'hffea, 5'd16};
			8'he1: code = '{16'hffeb, 5'd16};
			8'he2: code = '{16'hffec, 5'd16};
			8'he3: code = '{16'hffed, 5'd16};
			8'he4: code = '{16'hffee, 5'd16};
			8'he5: code = '{16'hffef, 5'd16};
			8'he6: code = '{16'hfff0, 5'd16};
			8'he7: code = '{16'hfff1, 5'd16};
			8'he8: code = '{16'hfff2, 5'd16};
			8'he9: code = '{16'hfff3, 5'd16};
			8'hea: code = '{16'hfff4, 5'd16};
			8'hf0: code = '{16'b11111111001, 5'd11};	// ZRL
			8'hf1: code = '{16'hfff5, 5'd16};
			8'hf2: code = '{16'hfff6, 5'd16};
			8'hf3: code = '{16'hfff7, 5'd16};
			8'hf4: code = '{16'hfff8, 5'd16};
			8'hf5: code = '{16'hfff9, 5'd16};
			8'hf6: code = '{16'hfffa, 5'd16};
			8'hf7: code = '{16'hfffb, 5'd16};
			8'hf8: code = '{16'hfffc, 5'd16};
			8'hf9: code = '{16'hfffd, 5'd16};
			8'hfa: code = '{16'hfffe, 5'd16};
			default: code = '{16'b1010, 5'd4};	// falls back to EOB
		endcase
	end

endmodule

// ==== design/ac_category_calc.sv ====
`timescale 1ns/1ns

module ac_category_calc (
	input jpeg_coef_pkg::coef_t coef,
	output jpeg_coef_pkg::cat_t category,
	output jpeg_coef_pkg::addl_t addl
);
	import jpeg_coef_pkg::*;

	logic [COEF_W-1:0] mag;
	coef_t addl_full;

	assign mag = coef[COEF_W-1] ? -coef : coef;

	// highest set bit of the magnitude, plus one
	always_comb begin
		category = '0;
		for (int i = 0; i < MAX_CAT; i++) begin
			if (mag[i])
				category = cat_t'(i + 1);
		end
	end

	// negative values send the ones' complement of the magnitude
	assign addl_full = coef[COEF_W-1] ? coef - coef_t'(1) : coef;
	assign addl = addl_full[ADDL_W-1:0];	// sign bit dropped

endmodule

// ==== design/jpeg_huff_pkg.sv ====
package jpeg_huff_pkg;

	localparam int CODE_W = 16;	// longest code in K.5
	localparam int LEN_W = 5;
	localparam int EXT_W = 26;	// 16 code bits plus 10 additional bits

	// code right-aligned, upper bits zero
	typedef struct packed {
		logic [CODE_W-1:0] code;
		logic [LEN_W-1:0] length;
	} huff_code_t;

	typedef struct packed {
		logic [EXT_W-1:0] ext_code;	// right-aligned
		logic [LEN_W-1:0] num_bits;
	} ac_out_t;

endpackage

// ==== design/jpeg_coef_pkg.sv ====
package jpeg_coef_pkg;

	localparam int COEF_W = 11;	// baseline AC coefficient, -1023..+1023
	localparam int RUN_W = 4;	// zero run 0..15
	localparam int CAT_W = 4;
	localparam int ADDL_W = 10;
	localparam int MAX_CAT = 10;	// largest AC size category

	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic [RUN_W-1:0] run_t;
	typedef logic [CAT_W-1:0] cat_t;
	typedef logic [ADDL_W-1:0] addl_t;

	// run in the high nibble, size in the low nibble
	typedef struct packed {
		run_t run;
		cat_t cat;
	} ac_sym_t;

endpackage
